// File: rtl/coreIsaPkg.sv
// Shared ISA definitions for the integer execute slice
// Field widths, opcode, ALU, branch and execute-unit encodings
`default_nettype none

package coreIsaPkg;

	parameter int InstrWidth = 32;
	parameter int DataWidth = 32;
	parameter int RegAddrWidth = 5;
	parameter int OpcodeWidth = 6;
	parameter int ImmWidth = 16;
	parameter int OffsetWidth = 26;

	// Primary opcodes in bits 31:26
	typedef enum logic [OpcodeWidth-1:0] {
		opAdd = 6'b00_0000,
		opSub = 6'b00_0001,
		opLhw = 6'b00_0010,
		opLlw = 6'b00_0011,
		opAnd = 6'b00_0100,
		opOr = 6'b00_0101,
		opXor = 6'b00_0110,
		opNot = 6'b00_0111,
		opSll = 6'b00_1000,
		opSrl = 6'b00_1001,
		opSra = 6'b00_1010,
		opFlush = 6'b00_1100,
		opBranch = 6'b01_0000,
		opCall = 6'b01_0001,
		opRet = 6'b01_0010,
		opLoad = 6'b01_0100,
		opStore = 6'b01_0101,
		opMult = 6'b01_0110,
		opDiv = 6'b01_0111,
		opFadd = 6'b01_1000,
		opFsub = 6'b01_1001,
		opFmult = 6'b01_1010,
		opFdiv = 6'b01_1011,
		opFtoi = 6'b01_1100,
		opItof = 6'b01_1101,
		opSqrt = 6'b01_1110,
		opHalt = 6'b01_1111,
		opEnqc = 6'b10_0000,
		opEnqd = 6'b10_0100,
		opDeqd = 6'b10_0101
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd = 4'b0000,
		aluSub = 4'b0001,
		aluLhw = 4'b0010,
		aluLlw = 4'b0011,
		aluAnd = 4'b0100,
		aluOr = 4'b0101,
		aluXor = 4'b0110,
		aluNot = 4'b0111,
		aluSll = 4'b1000,
		aluSrl = 4'b1001,
		aluSra = 4'b1010
	} aluOpT;

	// Branch conditions in bits 25:23
	typedef enum logic [2:0] {
		bNeq = 3'b000,
		bEq = 3'b001,
		bGt = 3'b010,
		bLt = 3'b011,
		bGte = 3'b100,
		bLte = 3'b101,
		bOvfl = 3'b110,
		bUncon = 3'b111
	} branchOpT;

	typedef enum logic [1:0] {
		exuAlu = 2'b00,
		exuMdu = 2'b01,
		exuFpu = 2'b10
	} exuOpT;

endpackage

`default_nettype wire

// File: rtl/Control.sv
// Combinational instruction decoder
// Register addresses, enables, unit selection and flag enables
`timescale 1ns/100ps
`default_nettype none

module Control import coreIsaPkg::*; (
	input logic [InstrWidth-1:0] instr,
	output logic [RegAddrWidth-1:0] addrRead0,
	output logic enRead0,
	output logic [RegAddrWidth-1:0] addrRead1,
	output logic enRead1,
	output logic [RegAddrWidth-1:0] addrWrite,
	output logic enWrite,
	output logic [RegAddrWidth-1:0] exuShift,
	output exuOpT exuOp,
	output aluOpT aluOp,
	output branchOpT branchOp,
	output logic branchCmd,
	output logic aluCmd,
	output logic halt,
	output logic memValid,
	output logic zeroEn,
	output logic negativeEn,
	output logic overflowEn,
	output logic [OffsetWidth-1:0] offset,
	output logic [ImmWidth-1:0] immediate
);

	opcodeT opcode;
	logic [RegAddrWidth-1:0] rd;
	logic [RegAddrWidth-1:0] rn1;
	logic [RegAddrWidth-1:0] rn2;
	logic flagEn;

	assign opcode = opcodeT'(instr[31:26]);
	assign rd = instr[25:21];
	assign rn1 = instr[20:16];
	assign rn2 = instr[15:11];

	assign branchOp = branchOpT'(instr[25:23]);
	assign offset = instr[OffsetWidth-1:0];
	assign immediate = instr[ImmWidth-1:0];
	assign branchCmd = (opcode == opBranch);
	assign halt = (opcode == opHalt);

	// All three flags share one enable rule
	assign zeroEn = flagEn;
	assign negativeEn = flagEn;
	assign overflowEn = flagEn;

	always_comb begin
		addrRead0 = rn1;
		addrRead1 = rn2;
		addrWrite = rd;
		enRead0 = 1'b1;
		enRead1 = 1'b1;
		enWrite = 1'b1;
		flagEn = 1'b1;
		exuShift = '0;
		exuOp = exuAlu;
		aluOp = aluAdd;
		aluCmd = 1'b0;
		memValid = 1'b0;
		case (opcode)
			opAdd: aluOp = aluAdd;
			opSub: aluOp = aluSub;
			opAnd: aluOp = aluAnd;
			opOr: aluOp = aluOr;
			opXor: aluOp = aluXor;
			opNot: begin
				aluOp = aluNot;
				enRead1 = 1'b0;
			end
			// Upper half load keeps the low half of rd
			opLhw: begin
				aluOp = aluLhw;
				addrRead0 = rd;
				enRead1 = 1'b0;
				aluCmd = 1'b1;
				flagEn = 1'b0;
			end
			opLlw: begin
				aluOp = aluLlw;
				enRead0 = 1'b0;
				enRead1 = 1'b0;
				aluCmd = 1'b1;
				flagEn = 1'b0;
			end
			opSll, opSrl, opSra: begin
				aluOp = (opcode == opSll) ? aluSll : ((opcode == opSrl) ? aluSrl : aluSra);
				enRead1 = 1'b0;
				exuShift = instr[4:0];
			end
			opBranch, opHalt: begin
				enRead0 = 1'b0;
				enRead1 = 1'b0;
				enWrite = 1'b0;
				flagEn = 1'b0;
			end
			// Memory, call/return and NPU work leaves the slice
			opFlush, opEnqc, opDeqd: begin
				enRead0 = 1'b0;
				enRead1 = 1'b0;
				enWrite = (opcode == opDeqd);
				flagEn = 1'b0;
				aluCmd = (opcode == opEnqc);
				memValid = 1'b1;
			end
			opCall, opRet: begin
				addrRead0 = 5'h01;
				addrRead1 = '0;
				addrWrite = 5'h01;
				enRead1 = (opcode == opRet);
				flagEn = 1'b0;
				memValid = 1'b1;
			end
			opLoad, opStore: begin
				addrRead1 = (opcode == opStore) ? rd : rn1;
				enRead1 = (opcode == opStore);
				enWrite = (opcode == opLoad);
				flagEn = 1'b0;
				aluCmd = 1'b1;
				memValid = 1'b1;
			end
			opEnqd: begin
				addrRead0 = rd;
				enRead1 = 1'b0;
				enWrite = 1'b0;
				flagEn = 1'b0;
				memValid = 1'b1;
			end
			opMult, opDiv: exuOp = exuMdu;
			opFadd, opFsub, opFmult, opFdiv: exuOp = exuFpu;
			opFtoi, opItof, opSqrt: begin
				exuOp = exuFpu;
				enRead1 = 1'b0;
			end
			// Unassigned opcodes do nothing
			default: begin
				enRead0 = 1'b0;
				enRead1 = 1'b0;
				enWrite = 1'b0;
				flagEn = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/registerFile.sv
// Register file with two combinational reads and one clocked write
`timescale 1ns/100ps
`default_nettype none

module registerFile import coreIsaPkg::*; #(
	parameter int RegCount = 32
) (
	input logic clk,
	input logic arstN,
	input logic [RegAddrWidth-1:0] addrRead0,
	input logic enRead0,
	input logic [RegAddrWidth-1:0] addrRead1,
	input logic enRead1,
	input logic writeEn,
	input logic [RegAddrWidth-1:0] writeAddr,
	input logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData0,
	output logic [DataWidth-1:0] readData1
);

	logic [DataWidth-1:0] regs [RegCount];

	// A write still pending from the previous cycle is returned directly
	function automatic logic [DataWidth-1:0] readPort(
		input logic [RegAddrWidth-1:0] addr,
		input logic en
	);
		logic [DataWidth-1:0] data;
		data = '0;
		if (en && (addr < RegCount)) begin
			data = (writeEn && (writeAddr == addr)) ? writeData : regs[addr];
		end
		return data;
	endfunction

	assign readData0 = readPort(addrRead0, enRead0);
	assign readData1 = readPort(addrRead1, enRead1);

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < RegCount; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && (writeAddr < RegCount)) begin
			regs[writeAddr] <= writeData;
		end
	end

endmodule

`default_nettype wire

// File: rtl/integerExecute.sv
// Integer ALU, flag generation and registered write-back stage
`timescale 1ns/100ps
`default_nettype none

module integerExecute import coreIsaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input exuOpT exuOp,
	input aluOpT aluOp,
	input logic aluCmd,
	input logic memValid,
	input logic [RegAddrWidth-1:0] exuShift,
	input logic [ImmWidth-1:0] immediate,
	input logic enWrite,
	input logic [RegAddrWidth-1:0] addrWrite,
	input logic zeroEn,
	input logic negativeEn,
	input logic overflowEn,
	input logic [DataWidth-1:0] readData0,
	input logic [DataWidth-1:0] readData1,
	input logic halted,
	output logic writeEn,
	output logic [RegAddrWidth-1:0] writeAddr,
	output logic [DataWidth-1:0] writeData,
	output logic resultValid,
	output logic foreign,
	output logic flagStrobe,
	output logic zeroFlag,
	output logic negativeFlag,
	output logic overflowFlag,
	output logic zeroUpd,
	output logic negativeUpd,
	output logic overflowUpd
);

	logic accept;
	logic isForeign;
	logic [DataWidth-1:0] opB;
	logic [DataWidth-1:0] aluResult;
	logic aluOverflow;

	assign accept = instrValid && !halted;
	assign isForeign = (exuOp != exuAlu) || memValid;
	assign opB = aluCmd ? {{(DataWidth-ImmWidth){1'b0}}, immediate} : readData1;

	always_comb begin
		aluResult = readData0 + opB;
		aluOverflow = 1'b0;
		case (aluOp)
			aluAdd: aluOverflow = (readData0[31] == opB[31]) && (aluResult[31] != readData0[31]);
			aluSub: begin
				aluResult = readData0 - opB;
				aluOverflow = (readData0[31] != opB[31]) && (aluResult[31] != readData0[31]);
			end
			aluLhw: aluResult = {opB[ImmWidth-1:0], readData0[ImmWidth-1:0]};
			aluLlw: aluResult = opB;
			aluAnd: aluResult = readData0 & opB;
			aluOr: aluResult = readData0 | opB;
			aluXor: aluResult = readData0 ^ opB;
			aluNot: aluResult = ~readData0;
			aluSll: aluResult = readData0 << exuShift;
			aluSrl: aluResult = readData0 >> exuShift;
			aluSra: aluResult = $signed(readData0) >>> exuShift;
			default: aluResult = readData0 + opB;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			writeEn <= 1'b0;
			foreign <= 1'b0;
			flagStrobe <= 1'b0;
		end else begin
			writeEn <= accept && !isForeign && enWrite;
			foreign <= accept && isForeign;
			flagStrobe <= accept && !isForeign && (zeroEn || negativeEn || overflowEn);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			writeAddr <= addrWrite;
			writeData <= aluResult;
			zeroFlag <= (aluResult == '0);
			negativeFlag <= aluResult[DataWidth-1];
			overflowFlag <= aluOverflow;
			zeroUpd <= zeroEn;
			negativeUpd <= negativeEn;
			overflowUpd <= overflowEn;
		end
	end

	assign resultValid = writeEn;

endmodule

`default_nettype wire

// File: rtl/flagBranchUnit.sv
// Flag register, branch condition evaluation and halt latch
`timescale 1ns/100ps
`default_nettype none

module flagBranchUnit import coreIsaPkg::*; (
	input logic clk,
	input logic arstN,
	input logic instrValid,
	input logic flagStrobe,
	input logic zeroFlag,
	input logic negativeFlag,
	input logic overflowFlag,
	input logic zeroUpd,
	input logic negativeUpd,
	input logic overflowUpd,
	input logic branchCmd,
	input branchOpT branchOp,
	input logic [OffsetWidth-1:0] offset,
	input logic halt,
	output logic branchValid,
	output logic branchTaken,
	output logic [OffsetWidth-1:0] branchOffset,
	output logic halted
);

	logic zeroQ;
	logic negativeQ;
	logic overflowQ;
	logic zeroCur;
	logic negativeCur;
	logic overflowCur;
	logic accept;
	logic condMet;

	// Flags including the update from the previous instruction
	assign zeroCur = (flagStrobe && zeroUpd) ? zeroFlag : zeroQ;
	assign negativeCur = (flagStrobe && negativeUpd) ? negativeFlag : negativeQ;
	assign overflowCur = (flagStrobe && overflowUpd) ? overflowFlag : overflowQ;

	assign accept = instrValid && !halted;

	always_comb begin
		case (branchOp)
			bNeq: condMet = !zeroCur;
			bEq: condMet = zeroCur;
			bGt: condMet = !zeroCur && !negativeCur;
			bLt: condMet = negativeCur;
			bGte: condMet = !negativeCur;
			bLte: condMet = zeroCur || negativeCur;
			bOvfl: condMet = overflowCur;
			default: condMet = 1'b1;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			zeroQ <= 1'b0;
			negativeQ <= 1'b0;
			overflowQ <= 1'b0;
			branchValid <= 1'b0;
			branchTaken <= 1'b0;
			halted <= 1'b0;
		end else begin
			zeroQ <= zeroCur;
			negativeQ <= negativeCur;
			overflowQ <= overflowCur;
			branchValid <= accept && branchCmd;
			branchTaken <= accept && branchCmd && condMet;
			if (accept && halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept && branchCmd) begin
			branchOffset <= offset;
		end
	end

endmodule

`default_nettype wire

// File: rtl/executeSlice.sv
// Decode-and-execute slice top level
// Decoder, register file, integer execute and flag/branch unit
`timescale 1ns/100ps
`default_nettype none

module executeSlice import coreIsaPkg::*; #(
	parameter int RegCount = 32
) (
	input logic clk,
	input logic arstN,
	input logic [InstrWidth-1:0] instr,
	input logic instrValid,
	output logic [DataWidth-1:0] result,
	output logic [RegAddrWidth-1:0] writeAddr,
	output logic resultValid,
	output logic foreign,
	output logic branchValid,
	output logic branchTaken,
	output logic [OffsetWidth-1:0] branchOffset,
	output logic halted
);

	logic [RegAddrWidth-1:0] addrRead0;
	logic [RegAddrWidth-1:0] addrRead1;
	logic [RegAddrWidth-1:0] addrWrite;
	logic [RegAddrWidth-1:0] exuShift;
	logic enRead0;
	logic enRead1;
	logic enWrite;
	exuOpT exuOp;
	aluOpT aluOp;
	branchOpT branchOp;
	logic branchCmd;
	logic aluCmd;
	logic halt;
	logic memValid;
	logic zeroEn;
	logic negativeEn;
	logic overflowEn;
	logic [OffsetWidth-1:0] offset;
	logic [ImmWidth-1:0] immediate;
	logic [DataWidth-1:0] readData0;
	logic [DataWidth-1:0] readData1;
	logic writeEn;
	logic flagStrobe;
	logic zeroFlag;
	logic negativeFlag;
	logic overflowFlag;
	logic zeroUpd;
	logic negativeUpd;
	logic overflowUpd;

	Control control_i (
		.instr(instr),
		.addrRead0(addrRead0),
		.enRead0(enRead0),
		.addrRead1(addrRead1),
		.enRead1(enRead1),
		.addrWrite(addrWrite),
		.enWrite(enWrite),
		.exuShift(exuShift),
		.exuOp(exuOp),
		.aluOp(aluOp),
		.branchOp(branchOp),
		.branchCmd(branchCmd),
		.aluCmd(aluCmd),
		.halt(halt),
		.memValid(memValid),
		.zeroEn(zeroEn),
		.negativeEn(negativeEn),
		.overflowEn(overflowEn),
		.offset(offset),
		.immediate(immediate)
	);

	registerFile #(
		.RegCount(RegCount)
	) registerFile_i (
		.clk(clk),
		.arstN(arstN),
		.addrRead0(addrRead0),
		.enRead0(enRead0),
		.addrRead1(addrRead1),
		.enRead1(enRead1),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(result),
		.readData0(readData0),
		.readData1(readData1)
	);

	integerExecute integerExecute_i (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.exuOp(exuOp),
		.aluOp(aluOp),
		.aluCmd(aluCmd),
		.memValid(memValid),
		.exuShift(exuShift),
		.immediate(immediate),
		.enWrite(enWrite),
		.addrWrite(addrWrite),
		.zeroEn(zeroEn),
		.negativeEn(negativeEn),
		.overflowEn(overflowEn),
		.readData0(readData0),
		.readData1(readData1),
		.halted(halted),
		.writeEn(writeEn),
		.writeAddr(writeAddr),
		.writeData(result),
		.resultValid(resultValid),
		.foreign(foreign),
		.flagStrobe(flagStrobe),
		.zeroFlag(zeroFlag),
		.negativeFlag(negativeFlag),
		.overflowFlag(overflowFlag),
		.zeroUpd(zeroUpd),
		.negativeUpd(negativeUpd),
		.overflowUpd(overflowUpd)
	);

	flagBranchUnit flagBranchUnit_i (
		.clk(clk),
		.arstN(arstN),
		.instrValid(instrValid),
		.flagStrobe(flagStrobe),
		.zeroFlag(zeroFlag),
		.negativeFlag(negativeFlag),
		.overflowFlag(overflowFlag),
		.zeroUpd(zeroUpd),
		.negativeUpd(negativeUpd),
		.overflowUpd(overflowUpd),
		.branchCmd(branchCmd),
		.branchOp(branchOp),
		.offset(offset),
		.halt(halt),
		.branchValid(branchValid),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.halted(halted)
	);

endmodule

`default_nettype wire

// File: sim/executeSliceTb.sv
// Testbench for the execute slice, driven by a golden stimulus file
// Line checker, cycle timeout and closing error summary
`timescale 1ns/100ps
`default_nettype none

module executeSliceTb;

	localparam int MaxLines = 256;
	localparam int ResetCycles = 3;
	localparam int TimeoutMargin = 20;
	localparam string GoldenPath = "sim/executeSliceGolden.txt";

	logic clk;
	logic arstN;
	logic [31:0] instr;
	logic instrValid;
	logic [31:0] result;
	logic [4:0] writeAddr;
	logic resultValid;
	logic foreign;
	logic branchValid;
	logic branchTaken;
	logic [25:0] branchOffset;
	logic halted;

	// Golden columns with one entry per instruction line
	logic [31:0] goldInstr [MaxLines];
	logic goldValid [MaxLines];
	logic [31:0] goldResult [MaxLines];
	logic [4:0] goldAddr [MaxLines];
	logic goldResultValid [MaxLines];
	logic goldForeign [MaxLines];
	logic goldBranchValid [MaxLines];
	logic goldBranchTaken [MaxLines];
	logic goldHalted [MaxLines];

	int lineCount;
	int cycleCount;
	int cycleLimit = MaxLines + TimeoutMargin;
	int checkCount;
	int valueErrors;
	int otherErrors;

	executeSlice #(
		.RegCount(32)
	) dut_i (
		.clk(clk),
		.arstN(arstN),
		.instr(instr),
		.instrValid(instrValid),
		.result(result),
		.writeAddr(writeAddr),
		.resultValid(resultValid),
		.foreign(foreign),
		.branchValid(branchValid),
		.branchTaken(branchTaken),
		.branchOffset(branchOffset),
		.halted(halted)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			otherErrors++;
			printCounts();
			$display("TB FAILED");
			$finish;
		end
	end

	task automatic loadGolden();
		int fd;
		int n;
		string text;
		logic [31:0] fInstr;
		logic [31:0] fValid;
		logic [31:0] fResult;
		logic [31:0] fAddr;
		logic [31:0] fRv;
		logic [31:0] fForeign;
		logic [31:0] fBv;
		logic [31:0] fBt;
		logic [31:0] fHalt;
		fd = $fopen(GoldenPath, "r");
		if (fd == 0) begin
			$display("Error: cannot open golden file %s", GoldenPath);
			otherErrors++;
		end else begin
			while (!$feof(fd) && (lineCount < MaxLines)) begin
				text = "";
				void'($fgets(text, fd));
				// Comment and blank lines do not match all nine fields
				n = $sscanf(text, "%h %h %h %h %h %h %h %h %h", fInstr, fValid, fResult,
					fAddr, fRv, fForeign, fBv, fBt, fHalt);
				if (n == 9) begin
					goldInstr[lineCount] = fInstr;
					goldValid[lineCount] = fValid[0];
					goldResult[lineCount] = fResult;
					goldAddr[lineCount] = fAddr[4:0];
					goldResultValid[lineCount] = fRv[0];
					goldForeign[lineCount] = fForeign[0];
					goldBranchValid[lineCount] = fBv[0];
					goldBranchTaken[lineCount] = fBt[0];
					goldHalted[lineCount] = fHalt[0];
					lineCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic checkValue(input int idx, input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp) else begin
			valueErrors++;
			$display("[FAIL] line %0d %s got 0x%h expected 0x%h", idx, name, got, exp);
		end
	endtask

	// Outputs seen one cycle after golden line idx was strobed
	task automatic checkLine(input int idx);
		checkValue(idx, "resultValid", resultValid, goldResultValid[idx]);
		if (goldResultValid[idx]) begin
			checkValue(idx, "result", result, goldResult[idx]);
			checkValue(idx, "writeAddr", writeAddr, goldAddr[idx]);
		end
		checkValue(idx, "foreign", foreign, goldForeign[idx]);
		checkValue(idx, "branchValid", branchValid, goldBranchValid[idx]);
		checkValue(idx, "branchTaken", branchTaken, goldBranchTaken[idx]);
		// Branch offset field sits in bits 25:0
		if (goldBranchValid[idx]) begin
			checkValue(idx, "branchOffset", branchOffset, {6'b0, goldInstr[idx][25:0]});
		end
		checkValue(idx, "halted", halted, goldHalted[idx]);
	endtask

	task automatic printCounts();
		$display("Summary: %0d checks, %0d value errors, %0d other errors", checkCount,
			valueErrors, otherErrors);
	endtask

	initial begin
		int idx;
		clk = 1'b0;
		arstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		lineCount = 0;
		cycleCount = 0;
		checkCount = 0;
		valueErrors = 0;
		otherErrors = 0;
		loadGolden();
		cycleLimit = lineCount + TimeoutMargin;
		repeat (ResetCycles) @(posedge clk);
		#1;
		arstN = 1'b1;
		@(negedge clk);
		// Index -1 marks the reset state in error lines
		checkValue(-1, "resultValid", resultValid, 32'h0);
		checkValue(-1, "foreign", foreign, 32'h0);
		checkValue(-1, "branchValid", branchValid, 32'h0);
		checkValue(-1, "halted", halted, 32'h0);
		for (idx = 0; idx < lineCount; idx++) begin
			@(posedge clk);
			#1;
			instr = goldInstr[idx];
			instrValid = goldValid[idx];
			@(negedge clk);
			if (idx > 0) begin
				checkLine(idx - 1);
			end
		end
		@(posedge clk);
		#1;
		instr = '0;
		instrValid = 1'b0;
		@(negedge clk);
		if (lineCount > 0) begin
			checkLine(lineCount - 1);
		end
		printCounts();
		if ((valueErrors == 0) && (otherErrors == 0)) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim/executeSliceGolden.txt
// instr valid result writeAddr resultValid foreign branchValid branchTaken halted, all hex
// Expected columns hold the outputs one cycle after the strobe, result/writeAddr only if resultValid
0C201234 1 00001234 01 1 0 0 0 0
0820ABCD 1 ABCD1234 01 1 0 0 0 0
0C4000FF 1 000000FF 02 1 0 0 0 0
08400F0F 1 0F0F00FF 02 1 0 0 0 0
00611000 1 BADC1333 03 1 0 0 0 0
04830800 1 0F0F00FF 04 1 0 0 0 0
10A11000 1 0B0D0034 05 1 0 0 0 0
14C11000 1 AFCF12FF 06 1 0 0 0 0
18E11000 1 A4C212CB 07 1 0 0 0 0
1D010000 1 5432EDCB 08 1 0 0 0 0
21220004 1 F0F00FF0 09 1 0 0 0 0
25410008 1 00ABCD12 0A 1 0 0 0 0
29610008 1 FFABCD12 0B 1 0 0 0 0
05821000 1 00000000 0C 1 0 0 0 0
0DA08000 1 00008000 0D 1 0 0 0 0
40000010 1 00000000 00 0 0 1 0 0
40800011 1 00000000 00 0 0 1 1 0
41000012 1 00000000 00 0 0 1 0 0
41800013 1 00000000 00 0 0 1 0 0
42000014 1 00000000 00 0 0 1 1 0
42800015 1 00000000 00 0 0 1 1 0
43000016 1 00000000 00 0 0 1 0 0
43800017 1 00000000 00 0 0 1 1 0
05C11000 1 9CBE1135 0E 1 0 0 0 0
41800020 1 00000000 00 0 0 1 1 0
41000021 1 00000000 00 0 0 1 0 0
42000022 1 00000000 00 0 0 1 0 0
01E73800 1 49842596 0F 1 0 0 0 0
09E07FFF 1 7FFF2596 0F 1 0 0 0 0
43000030 1 00000000 00 0 0 1 1 0
41000031 1 00000000 00 0 0 1 1 0
50220000 1 00000000 00 0 1 0 0 0
58410800 1 00000000 00 0 1 0 0 0
60611000 1 00000000 00 0 1 0 0 0
90800000 1 00000000 00 0 1 0 0 0
16011000 1 AFCF12FF 10 1 0 0 0 0
1A232000 1 B5D313CC 11 1 0 0 0 0
00000000 0 00000000 00 0 0 0 0 0
7C000000 1 00000000 00 0 0 0 0 1
02411000 1 00000000 00 0 0 0 0 1

// File: executeSlice.f
rtl/coreIsaPkg.sv
rtl/Control.sv
rtl/registerFile.sv
rtl/integerExecute.sv
rtl/flagBranchUnit.sv
rtl/executeSlice.sv
sim/executeSliceTb.sv

// File: Bender.yml
package:
  name: executeSlice

sources:
  - rtl/coreIsaPkg.sv
  - rtl/Control.sv
  - rtl/registerFile.sv
  - rtl/integerExecute.sv
  - rtl/flagBranchUnit.sv
  - rtl/executeSlice.sv
  - target: simulation
    files:
      - sim/executeSliceTb.sv
